//--- ssr_cfg_decode.sv
/*
 * Configuration decoder.
 * Turns the config word into per-mover write strobes with broadcast,
 * merges write-ready and selects read data from the addressed mover.
 */

`timescale 1ns/1ps

module ssr_cfg_decode import ssr_pkg::*; (
  // Config bus from outside
  input  logic [11:0]               cfg_word_i,
  input  logic                      cfg_write_i,
  input  logic [31:0]               cfg_wdata_i,
  output logic [31:0]               cfg_rdata_o,
  output logic                      cfg_wready_o,
  // Config bus towards the movers
  output logic [4:0]                mv_word_o,
  output logic [NUM_SSRS-1:0]       mv_write_o,
  output logic [31:0]               mv_wdata_o,
  input  logic [NUM_SSRS-1:0][31:0] mv_rdata_i,
  input  logic [NUM_SSRS-1:0]       mv_wready_i
);

  logic [4:0]          sel;
  logic                sel_bcast;
  logic [NUM_SSRS-1:0] strobe;

  assign sel       = cfg_word_i[CFG_SEL_MSB:CFG_SEL_LSB];
  assign sel_bcast = (sel == CFG_BROADCAST);

  // Register index and write data go to every mover unchanged
  assign mv_word_o  = cfg_word_i[4:0];
  assign mv_wdata_o = cfg_wdata_i;

  // One strobe per mover, all of them on broadcast
  always_comb begin
    for (int i = 0; i < NUM_SSRS; i++) begin
      strobe[i] = sel_bcast || (sel == 5'(i));
    end
  end

  // Ready is the addressed mover's, the AND of all on broadcast
  // An unmapped select is always ready and has no strobe
  always_comb begin
    cfg_wready_o = 1'b1;
    if (sel_bcast) begin
      cfg_wready_o = &mv_wready_i;
    end else begin
      for (int i = 0; i < NUM_SSRS; i++) begin
        if (sel == 5'(i)) begin
          cfg_wready_o = mv_wready_i[i];
        end
      end
    end
  end

  // Writes only reach the movers once the whole target is ready
  assign mv_write_o = strobe & {NUM_SSRS{cfg_write_i & cfg_wready_o}};

  // Read data of the selected mover, zero for unmapped or broadcast
  always_comb begin
    cfg_rdata_o = '0;
    for (int i = 0; i < NUM_SSRS; i++) begin
      if (sel == 5'(i)) begin
        cfg_rdata_o = mv_rdata_i[i];
      end
    end
  end

endmodule

//--- ssr_data_mover.sv
/*
 * Data mover for one stream register.
 * Holds the job registers, walks base/stride/bound addresses, issues
 * credit-limited reads into a small response buffer and forwards writes.
 */

`timescale 1ns/1ps

module ssr_data_mover import ssr_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  // Config access
  input  logic [4:0]  cfg_word_i,
  input  logic        cfg_write_i,
  input  logic [31:0] cfg_wdata_i,
  output logic [31:0] cfg_rdata_o,
  output logic        cfg_wready_o,
  // Lane from the switch
  input  lane_req_t   lane_req_i,
  output lane_rsp_t   lane_rsp_o,
  // Memory port
  output mem_req_t    mem_req_o,
  input  mem_rsp_t    mem_rsp_i
);

  // Job configuration and address state
  addr_t       base_q;
  addr_t       stride_q;
  addr_t       addr_q;
  addr_t       rd_addr_q;
  logic [31:0] bound_q;
  logic [31:0] iss_idx_q;
  logic [31:0] cmp_idx_q;

  // Job control
  logic write_q;
  logic busy_q;
  logic done_q;
  logic iss_end_q;
  logic rd_req_valid_q;
  logic rd_rsp_exp_q;

  // Credits and read buffer
  logic [CREDIT_WIDTH-1:0] credit_q;
  logic [CREDIT_WIDTH-1:0] fill_q;
  logic [PTR_WIDTH-1:0]    wr_ptr_q;
  logic [PTR_WIDTH-1:0]    rd_ptr_q;
  data_t                   buf_q [DATA_CREDITS];

  cfg_status_t status_wr;
  cfg_status_t status_rd;
  logic        cfg_we;
  logic        job_start;
  logic        wr_lane_ok;
  logic        rd_issue;
  logic        wr_fire;
  logic        rd_pop;
  logic        rsp_push;
  logic        issue;
  logic        complete;

  // A new job is only taken while idle
  assign cfg_wready_o = ~busy_q;
  assign cfg_we       = cfg_write_i & ~busy_q;
  assign status_wr    = cfg_wdata_i;
  assign job_start    = cfg_we && (cfg_word_i == CFG_REG_STATUS);

  assign rd_issue   = busy_q & ~write_q & ~iss_end_q & (credit_q != '0);
  assign wr_lane_ok = busy_q & write_q & ~iss_end_q;
  assign wr_fire    = lane_req_i.valid & lane_req_i.write & wr_lane_ok;
  assign rd_pop     = lane_req_i.valid & ~lane_req_i.write & (fill_q != '0);
  assign rsp_push   = rd_rsp_exp_q & mem_rsp_i.valid;
  assign issue      = rd_issue | wr_fire;
  assign complete   = rd_pop | wr_fire;

  always_ff @(posedge clk_i) begin
    if (cfg_we) begin
      case (cfg_word_i)
        CFG_REG_BOUND:  bound_q  <= cfg_wdata_i;
        CFG_REG_STRIDE: stride_q <= cfg_wdata_i;
        CFG_REG_BASE:   base_q   <= cfg_wdata_i;
        default: ;
      endcase
    end
  end

  // Busy from start until the last element completes, then done
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      write_q   <= 1'b0;
      iss_end_q <= 1'b0;
    end else if (job_start) begin
      busy_q    <= 1'b1;
      done_q    <= 1'b0;
      write_q   <= status_wr.write;
      iss_end_q <= 1'b0;
    end else begin
      if (issue && (iss_idx_q == bound_q)) begin
        iss_end_q <= 1'b1;
      end
      if (complete && (cmp_idx_q == bound_q)) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // Address generator and element counters
  always_ff @(posedge clk_i) begin
    if (job_start) begin
      addr_q    <= base_q;
      iss_idx_q <= '0;
      cmp_idx_q <= '0;
    end else begin
      if (issue) begin
        addr_q    <= addr_q + stride_q;
        iss_idx_q <= iss_idx_q + 1'b1;
      end
      if (complete) begin
        cmp_idx_q <= cmp_idx_q + 1'b1;
      end
    end
    if (rd_issue) begin
      rd_addr_q <= addr_q;
    end
  end

  // Read requests leave one cycle after issue, data returns one cycle later
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_req_valid_q <= 1'b0;
      rd_rsp_exp_q   <= 1'b0;
      credit_q       <= CREDIT_WIDTH'(DATA_CREDITS);
    end else begin
      rd_req_valid_q <= rd_issue;
      rd_rsp_exp_q   <= rd_req_valid_q;
      if (rd_issue && !rd_pop) begin
        credit_q <= credit_q - 1'b1;
      end else if (!rd_issue && rd_pop) begin
        credit_q <= credit_q + 1'b1;
      end
    end
  end

  // Response buffer, cannot overflow since every entry holds a credit
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (rsp_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (rsp_push && !rd_pop) begin
        fill_q <= fill_q + 1'b1;
      end else if (!rsp_push && rd_pop) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_push) begin
      buf_q[wr_ptr_q] <= mem_rsp_i.rdata;
    end
  end

  assign lane_rsp_o.ready = lane_req_i.write ? wr_lane_ok : (fill_q != '0);
  assign lane_rsp_o.rdata = buf_q[rd_ptr_q];

  // Write jobs go straight to memory at the current address
  always_comb begin
    mem_req_o = '0;
    if (write_q) begin
      mem_req_o.valid = wr_fire;
      mem_req_o.write = 1'b1;
      mem_req_o.addr  = addr_q;
      mem_req_o.wdata = lane_req_i.wdata;
    end else begin
      mem_req_o.valid = rd_req_valid_q;
      mem_req_o.addr  = rd_addr_q;
    end
  end

  always_comb begin
    status_rd       = '0;
    status_rd.done  = done_q;
    status_rd.busy  = busy_q;
    status_rd.write = write_q;
    case (cfg_word_i)
      CFG_REG_STATUS: cfg_rdata_o = status_rd;
      CFG_REG_BOUND:  cfg_rdata_o = bound_q;
      CFG_REG_STRIDE: cfg_rdata_o = stride_q;
      CFG_REG_BASE:   cfg_rdata_o = base_q;
      default:        cfg_rdata_o = '0;
    endcase
  end

endmodule

//--- ssr_pkg.sv
/*
 * Shared definitions for the stream register subsystem.
 * Widths, mover count, credit depth, register map and config layout,
 * plus the packed structs for memory, lane and status traffic.
 */

package ssr_pkg;

  // Datapath widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;

  // Number of data movers and read buffer depth per mover
  localparam int unsigned NUM_SSRS     = 2;
  localparam int unsigned DATA_CREDITS = 4;
  localparam int unsigned CREDIT_WIDTH = $clog2(DATA_CREDITS + 1);
  localparam int unsigned PTR_WIDTH    = $clog2(DATA_CREDITS);

  // Core register served by each mover
  localparam logic [NUM_SSRS-1:0][4:0] SSR_REGS = {5'd1, 5'd0};

  // Config word fields: upper bits pick the mover, lower bits the register
  localparam int unsigned CFG_SEL_MSB = 11;
  localparam int unsigned CFG_SEL_LSB = 7;
  localparam logic [4:0]  CFG_BROADCAST = 5'h1f;

  // Register map inside one mover
  localparam logic [4:0] CFG_REG_STATUS = 5'd0;
  localparam logic [4:0] CFG_REG_BOUND  = 5'd1;
  localparam logic [4:0] CFG_REG_STRIDE = 5'd2;
  localparam logic [4:0] CFG_REG_BASE   = 5'd3;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  // STATUS register layout, same for read and write
  // Writes only use the write field, which sets the job direction
  typedef struct packed {
    logic [28:0] reserved;
    logic        write;
    logic        busy;
    logic        done;
  } cfg_status_t;

  // Memory port of one mover
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    data_t rdata;
  } mem_rsp_t;

  // Lane between the switch and one mover
  typedef struct packed {
    logic  valid;
    logic  write;
    data_t wdata;
  } lane_req_t;

  typedef struct packed {
    logic  ready;
    data_t rdata;
  } lane_rsp_t;

endpackage

//--- ssr_streamer.sv
/*
 * Stream register subsystem top level.
 * Joins the config decoder, one data mover per stream register and the
 * register switch; exposes config, core and memory ports.
 */

`timescale 1ns/1ps

module ssr_streamer import ssr_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // Config bus
  input  logic [11:0]              cfg_word_i,
  input  logic                     cfg_write_i,
  input  logic [31:0]              cfg_wdata_i,
  output logic [31:0]              cfg_rdata_o,
  output logic                     cfg_wready_o,
  // Core streams
  input  logic [4:0]               ssr_raddr_i,
  input  logic                     ssr_rvalid_i,
  output logic                     ssr_rready_o,
  output data_t                    ssr_rdata_o,
  input  logic [4:0]               ssr_waddr_i,
  input  logic                     ssr_wvalid_i,
  input  data_t                    ssr_wdata_i,
  output logic                     ssr_wready_o,
  // Memory ports, one per mover
  output mem_req_t [NUM_SSRS-1:0]  mem_req_o,
  input  mem_rsp_t [NUM_SSRS-1:0]  mem_rsp_i
);

  logic [4:0]                mv_word;
  logic [NUM_SSRS-1:0]       mv_write;
  logic [31:0]               mv_wdata;
  logic [NUM_SSRS-1:0][31:0] mv_rdata;
  logic [NUM_SSRS-1:0]       mv_wready;
  lane_req_t [NUM_SSRS-1:0]  lane_req;
  lane_rsp_t [NUM_SSRS-1:0]  lane_rsp;

  ssr_cfg_decode u_cfg_decode (
    .cfg_word_i   ( cfg_word_i   ),
    .cfg_write_i  ( cfg_write_i  ),
    .cfg_wdata_i  ( cfg_wdata_i  ),
    .cfg_rdata_o  ( cfg_rdata_o  ),
    .cfg_wready_o ( cfg_wready_o ),
    .mv_word_o    ( mv_word      ),
    .mv_write_o   ( mv_write     ),
    .mv_wdata_o   ( mv_wdata     ),
    .mv_rdata_i   ( mv_rdata     ),
    .mv_wready_i  ( mv_wready    )
  );

  for (genvar i = 0; i < NUM_SSRS; i++) begin : gen_movers
    ssr_data_mover u_mover (
      .clk_i        ( clk_i         ),
      .rst_i        ( rst_i         ),
      .cfg_word_i   ( mv_word       ),
      .cfg_write_i  ( mv_write[i]   ),
      .cfg_wdata_i  ( mv_wdata      ),
      .cfg_rdata_o  ( mv_rdata[i]   ),
      .cfg_wready_o ( mv_wready[i]  ),
      .lane_req_i   ( lane_req[i]   ),
      .lane_rsp_o   ( lane_rsp[i]   ),
      .mem_req_o    ( mem_req_o[i]  ),
      .mem_rsp_i    ( mem_rsp_i[i]  )
    );
  end

  ssr_switch u_switch (
    .ssr_raddr_i  ( ssr_raddr_i  ),
    .ssr_rvalid_i ( ssr_rvalid_i ),
    .ssr_rready_o ( ssr_rready_o ),
    .ssr_rdata_o  ( ssr_rdata_o  ),
    .ssr_waddr_i  ( ssr_waddr_i  ),
    .ssr_wvalid_i ( ssr_wvalid_i ),
    .ssr_wdata_i  ( ssr_wdata_i  ),
    .ssr_wready_o ( ssr_wready_o ),
    .lane_req_o   ( lane_req     ),
    .lane_rsp_i   ( lane_rsp     )
  );

endmodule

//--- ssr_switch.sv
/*
 * Register switch.
 * Steers the core read and write ports onto the lane of the mover that
 * serves the addressed register and returns that lane's ready and data.
 */

`timescale 1ns/1ps

module ssr_switch import ssr_pkg::*; (
  // Core read port
  input  logic [4:0]                ssr_raddr_i,
  input  logic                      ssr_rvalid_i,
  output logic                      ssr_rready_o,
  output data_t                     ssr_rdata_o,
  // Core write port
  input  logic [4:0]                ssr_waddr_i,
  input  logic                      ssr_wvalid_i,
  input  data_t                     ssr_wdata_i,
  output logic                      ssr_wready_o,
  // Lanes to the movers
  output lane_req_t [NUM_SSRS-1:0]  lane_req_o,
  input  lane_rsp_t [NUM_SSRS-1:0]  lane_rsp_i
);

  logic [NUM_SSRS-1:0] r_match;
  logic [NUM_SSRS-1:0] w_match;
  logic [NUM_SSRS-1:0] r_hit;
  logic [NUM_SSRS-1:0] w_hit;

  always_comb begin
    for (int i = 0; i < NUM_SSRS; i++) begin
      r_match[i] = (ssr_raddr_i == SSR_REGS[i]);
      w_match[i] = (ssr_waddr_i == SSR_REGS[i]);
      r_hit[i]   = r_match[i] & ssr_rvalid_i;
      w_hit[i]   = w_match[i] & ssr_wvalid_i;
    end
  end

  // Write port takes the lane when both ports hit the same mover
  always_comb begin
    for (int i = 0; i < NUM_SSRS; i++) begin
      lane_req_o[i].valid = r_hit[i] | w_hit[i];
      lane_req_o[i].write = w_hit[i];
      lane_req_o[i].wdata = ssr_wdata_i;
    end
  end

  // Unmapped registers match no lane and never see ready
  always_comb begin
    ssr_rready_o = 1'b0;
    ssr_rdata_o  = '0;
    ssr_wready_o = 1'b0;
    for (int i = 0; i < NUM_SSRS; i++) begin
      if (r_match[i]) begin
        ssr_rready_o = lane_rsp_i[i].ready & ~w_hit[i];
        ssr_rdata_o  = lane_rsp_i[i].rdata;
      end
      if (w_match[i]) begin
        ssr_wready_o = lane_rsp_i[i].ready & w_hit[i];
      end
    end
  end

endmodule

//--- tb_ssr_mem.sv
/*
 * Testbench memory model for one mover port.
 * One-cycle read latency, writes in the request cycle,
 * backdoor fill and peek for preload and inspection.
 */

`timescale 1ns/1ps

module tb_ssr_mem import ssr_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o
);

  localparam int unsigned MEM_WORDS = 4096;

  data_t mem [MEM_WORDS];

  // Byte address to word index, 16 KiB window
  function automatic logic [11:0] word_idx(input addr_t addr);
    return addr[13:2];
  endfunction

  // Backdoor preload, each word holds its byte address XOR the pattern
  task automatic fill(input data_t pattern);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = data_t'(i * 4) ^ pattern;
    end
  endtask

  // Backdoor inspection
  function automatic data_t peek(input addr_t addr);
    return mem[word_idx(addr)];
  endfunction

  always @(posedge clk_i) begin
    if (rst_i) begin
      rsp_o <= '0;
    end else begin
      rsp_o.valid <= req_i.valid & ~req_i.write;
      rsp_o.rdata <= mem[word_idx(req_i.addr)];
      if (req_i.valid && req_i.write) begin
        mem[word_idx(req_i.addr)] <= req_i.wdata;
      end
    end
  end

endmodule

//--- tb_ssr_streamer.sv
/*
 * Directed testbench for the stream register subsystem.
 * Config readback, read and write streams, credit back-pressure,
 * broadcast and busy handling, done status and unmapped registers.
 */

`timescale 1ns/1ps

module tb_ssr_streamer import ssr_pkg::*;;

  localparam data_t PATTERN        = 32'hA5A5_0000;
  localparam int    TIMEOUT_CYCLES = 2000;

  logic        clk;
  logic        rst;
  logic [11:0] cfg_word;
  logic        cfg_write;
  logic [31:0] cfg_wdata;
  logic [31:0] cfg_rdata;
  logic        cfg_wready;
  logic [4:0]  ssr_raddr;
  logic        ssr_rvalid;
  logic        ssr_rready;
  data_t       ssr_rdata;
  logic [4:0]  ssr_waddr;
  logic        ssr_wvalid;
  data_t       ssr_wdata;
  logic        ssr_wready;
  mem_req_t [NUM_SSRS-1:0] mem_req;
  mem_rsp_t [NUM_SSRS-1:0] mem_rsp;

  integer seed;
  int     errors;
  int     ntests;
  int     cycles;
  int     inflight;
  int     max_inflight;

  ssr_streamer dut0 (
    .clk_i        ( clk        ),
    .rst_i        ( rst        ),
    .cfg_word_i   ( cfg_word   ),
    .cfg_write_i  ( cfg_write  ),
    .cfg_wdata_i  ( cfg_wdata  ),
    .cfg_rdata_o  ( cfg_rdata  ),
    .cfg_wready_o ( cfg_wready ),
    .ssr_raddr_i  ( ssr_raddr  ),
    .ssr_rvalid_i ( ssr_rvalid ),
    .ssr_rready_o ( ssr_rready ),
    .ssr_rdata_o  ( ssr_rdata  ),
    .ssr_waddr_i  ( ssr_waddr  ),
    .ssr_wvalid_i ( ssr_wvalid ),
    .ssr_wdata_i  ( ssr_wdata  ),
    .ssr_wready_o ( ssr_wready ),
    .mem_req_o    ( mem_req    ),
    .mem_rsp_i    ( mem_rsp    )
  );

  tb_ssr_mem mem0 (.clk_i(clk), .rst_i(rst), .req_i(mem_req[0]), .rsp_o(mem_rsp[0]));
  tb_ssr_mem mem1 (.clk_i(clk), .rst_i(rst), .req_i(mem_req[1]), .rsp_o(mem_rsp[1]));

  always #2 clk = ~clk;

  // Cycle limit for the whole run
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  // Mover 0 reads on the memory port minus pops by the core
  always @(posedge clk) begin
    if (rst) begin
      inflight = 0;
    end else begin
      if (mem_req[0].valid && !mem_req[0].write) inflight = inflight + 1;
      if (ssr_rvalid && ssr_rready && ssr_raddr == 5'd0) inflight = inflight - 1;
      if (inflight > max_inflight) max_inflight = inflight;
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    ntests++;
    if (errors == err0) $display("test %-18s ok", name);
    else $display("test %-18s FAILED with %0d errors", name, errors - err0);
  endtask

  // Config write, held until the addressed movers are ready
  task automatic cfg_wr(input logic [4:0] sel, input logic [4:0] idx, input data_t data);
    @(negedge clk);
    cfg_word  = {sel, 2'b00, idx};
    cfg_write = 1'b1;
    cfg_wdata = data;
    #1;
    while (!cfg_wready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    cfg_write = 1'b0;
  endtask

  task automatic cfg_rd(input logic [4:0] sel, input logic [4:0] idx, output data_t data);
    @(negedge clk);
    cfg_word  = {sel, 2'b00, idx};
    cfg_write = 1'b0;
    #1;
    data = cfg_rdata;
  endtask

  task automatic probe_wready(input logic [4:0] sel, output logic rdy);
    @(negedge clk);
    cfg_word  = {sel, 2'b00, CFG_REG_STATUS};
    cfg_write = 1'b0;
    #1;
    rdy = cfg_wready;
  endtask

  task automatic start_job(input logic [4:0] sel, input addr_t base, input addr_t stride,
                           input int n, input bit is_write);
    cfg_wr(sel, CFG_REG_BASE, base);
    cfg_wr(sel, CFG_REG_STRIDE, stride);
    cfg_wr(sel, CFG_REG_BOUND, n - 1);
    // Bit 2 of STATUS selects a write job
    cfg_wr(sel, CFG_REG_STATUS, is_write ? 32'h4 : 32'h0);
  endtask

  // One element from the core read port, optionally with random stalls
  task automatic pop_elem(input logic [4:0] r, input bit stall, output data_t data);
    bit taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      ssr_raddr  = r;
      ssr_rvalid = !(stall && ($random(seed) & 1));
      #1;
      if (ssr_rvalid && ssr_rready) begin
        data  = ssr_rdata;
        taken = 1'b1;
      end
    end
  endtask

  task automatic push_elem(input logic [4:0] r, input data_t data);
    bit taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      ssr_waddr  = r;
      ssr_wvalid = 1'b1;
      ssr_wdata  = data;
      #1;
      taken = ssr_wready;
    end
  endtask

  task automatic check_done(input logic [4:0] sel);
    data_t st;
    cfg_rd(sel, CFG_REG_STATUS, st);
    check("status done/busy", {30'b0, st[1:0]}, 32'h1);
  endtask

  task automatic run_read(input addr_t base, input addr_t stride, input int n, input bit stall);
    data_t v;
    start_job(5'd0, base, stride, n, 1'b0);
    for (int k = 0; k < n; k++) begin
      pop_elem(5'd0, stall, v);
      check("ssr_rdata_o", v, (base + k * stride) ^ PATTERN);
    end
    @(negedge clk);
    ssr_rvalid = 1'b0;
    check_done(5'd0);
  endtask

  task automatic test_cfg_readback();
    int    err0;
    data_t v;
    err0 = errors;
    check("mem_req[0].valid", mem_req[0].valid, 0);
    check("mem_req[1].valid", mem_req[1].valid, 0);
    check("ssr_rready_o", ssr_rready, 0);
    check("ssr_wready_o", ssr_wready, 0);
    for (int m = 0; m < NUM_SSRS; m++) begin
      cfg_rd(5'(m), CFG_REG_STATUS, v);
      check("status after reset", v[1:0], 0);
      cfg_wr(5'(m), CFG_REG_BASE, 32'h1000 + m * 32'h100);
      cfg_wr(5'(m), CFG_REG_STRIDE, 32'h4 + m * 32'h4);
      cfg_wr(5'(m), CFG_REG_BOUND, 32'h7 + m);
    end
    for (int m = 0; m < NUM_SSRS; m++) begin
      cfg_rd(5'(m), CFG_REG_BASE, v);
      check("BASE", v, 32'h1000 + m * 32'h100);
      cfg_rd(5'(m), CFG_REG_STRIDE, v);
      check("STRIDE", v, 32'h4 + m * 32'h4);
      cfg_rd(5'(m), CFG_REG_BOUND, v);
      check("BOUND", v, 32'h7 + m);
    end
    cfg_rd(5'd5, CFG_REG_BASE, v);
    check("cfg_rdata_o unmapped", v, 0);
    report_test("config readback", err0);
  endtask

  task automatic test_read_stream();
    int err0;
    err0 = errors;
    run_read(32'h100, 32'h4, 8, 1'b0);
    report_test("read stream", err0);
  endtask

  task automatic test_write_stream();
    int err0;
    err0 = errors;
    start_job(5'd1, 32'h800, 32'hC, 6, 1'b1);
    for (int k = 0; k < 6; k++) begin
      push_elem(5'd1, 32'hC0DE_0000 + k * 32'h0101_0101);
    end
    @(negedge clk);
    ssr_wvalid = 1'b0;
    check_done(5'd1);
    for (int k = 0; k < 6; k++) begin
      check("mem1 word", mem1.peek(32'h800 + k * 32'hC), 32'hC0DE_0000 + k * 32'h0101_0101);
    end
    report_test("write stream", err0);
  endtask

  task automatic test_credit_stall();
    int err0;
    err0 = errors;
    max_inflight = 0;
    run_read(32'h1000, 32'h24, 12, 1'b1);
    if (max_inflight > DATA_CREDITS) begin
      $display("Outstanding reads reached %0d, more than the %0d credits",
               max_inflight, DATA_CREDITS);
      errors++;
    end
    check("outstanding reads at end", inflight, 0);
    report_test("credit stall", err0);
  endtask

  task automatic test_broadcast_busy();
    int    err0;
    data_t v;
    logic  rdy;
    err0 = errors;
    cfg_wr(CFG_BROADCAST, CFG_REG_STRIDE, 32'h10);
    cfg_rd(5'd0, CFG_REG_STRIDE, v);
    check("STRIDE mover 0", v, 32'h10);
    cfg_rd(5'd1, CFG_REG_STRIDE, v);
    check("STRIDE mover 1", v, 32'h10);
    // Stride comes from the broadcast
    cfg_wr(5'd0, CFG_REG_BASE, 32'h300);
    cfg_wr(5'd0, CFG_REG_BOUND, 32'h3);
    cfg_wr(5'd0, CFG_REG_STATUS, 32'h0);
    probe_wready(5'd0, rdy);
    check("cfg_wready_o busy mover", rdy, 0);
    probe_wready(CFG_BROADCAST, rdy);
    check("cfg_wready_o broadcast", rdy, 0);
    probe_wready(5'd1, rdy);
    check("cfg_wready_o idle mover", rdy, 1);
    for (int k = 0; k < 4; k++) begin
      pop_elem(5'd0, 1'b0, v);
      check("ssr_rdata_o", v, (32'h300 + k * 32'h10) ^ PATTERN);
    end
    @(negedge clk);
    ssr_rvalid = 1'b0;
    probe_wready(5'd0, rdy);
    check("cfg_wready_o after job", rdy, 1);
    check_done(5'd0);
    report_test("broadcast busy", err0);
  endtask

  task automatic test_unmapped_reg();
    int err0;
    err0 = errors;
    repeat (8) begin
      @(negedge clk);
      ssr_raddr  = 5'd2;
      ssr_rvalid = 1'b1;
      ssr_waddr  = 5'd2;
      ssr_wvalid = 1'b1;
      ssr_wdata  = 32'hDEAD_BEEF;
      #1;
      check("ssr_rready_o reg 2", ssr_rready, 0);
      check("ssr_wready_o reg 2", ssr_wready, 0);
    end
    @(negedge clk);
    ssr_rvalid = 1'b0;
    ssr_wvalid = 1'b0;
    check_done(5'd0);
    check_done(5'd1);
    report_test("unmapped register", err0);
  endtask

  initial begin
    seed         = 32'h30c;
    errors       = 0;
    ntests       = 0;
    cycles       = 0;
    inflight     = 0;
    max_inflight = 0;
    clk          = 1'b0;
    rst          = 1'b1;
    cfg_word     = '0;
    cfg_write    = 1'b0;
    cfg_wdata    = '0;
    ssr_raddr    = '0;
    ssr_rvalid   = 1'b0;
    ssr_waddr    = '0;
    ssr_wvalid   = 1'b0;
    ssr_wdata    = '0;
    mem0.fill(PATTERN);
    mem1.fill(PATTERN);
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_cfg_readback();
    test_read_stream();
    test_write_stream();
    test_credit_stall();
    test_broadcast_busy();
    test_unmapped_reg();

    $display("Tests run: %0d, errors: %0d", ntests, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- verilog.f
ssr_pkg.sv
ssr_cfg_decode.sv
ssr_data_mover.sv
ssr_switch.sv
ssr_streamer.sv
tb_ssr_mem.sv
tb_ssr_streamer.sv
